// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/way_if.sv
      - source/mem_bus_if.sv
      - source/req_queue.sv
      - source/way_ram.sv
      - source/line_path.sv
      - source/host_port.sv
      - source/cache_ctrl.sv
      - source/cache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/mem_model.sv
      - tb/cache_tb.sv

// ==== cache_top.f ====
+incdir+source
source/cache_pkg.sv
source/way_if.sv
source/mem_bus_if.sv
source/req_queue.sv
source/way_ram.sv
source/line_path.sv
source/host_port.sv
source/cache_ctrl.sv
source/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

// ==== source/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Word address splits into tag, set index and word offset
`define CACHE_ADR_W      24
`define CACHE_DATA_W     32
`define CACHE_TAG_W      16
`define CACHE_IDX_W      6    // 64 sets
`define CACHE_OFS_W      2    // 4 words per line

`define CACHE_QDEPTH_LOG 2    // 4 queued requests

`endif

// ==== source/cache_ctrl.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module cache_ctrl import cache_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  output logic                     pop_o,
  input  logic                     empty_i,
  input  cache_req_t               head_i,
  output ctrl_cmd_e                cmd_o,
  output logic [`CACHE_IDX_W-1:0]  init_idx_o,
  output logic [`CACHE_OFS_W-1:0]  fill_ofs_o,
  output logic [`CACHE_OFS_W-1:0]  wb_ofs_o,
  output logic                     write_o,
  input  logic                     hit_i,
  input  logic                     victim_dirty_i,
  input  logic [`CACHE_TAG_W-1:0]  victim_tag_i,
  input  logic [`CACHE_DATA_W-1:0] victim_word_i,
  mem_bus_if.master                mem,
  output logic                     ready_en_o,
  output logic                     ctrl_idle_o,
  output logic                     done_o,
  output logic                     done_read_o,
  output logic                     ev_access_o,
  output logic                     ev_fill_o,
  output logic                     ev_wb_o
);

  typedef enum logic [2:0] {
    S_INIT, S_IDLE, S_LOOKUP, S_COMPARE, S_HIT, S_WB, S_FILL, S_REFILL
  } state_e;

  state_e                  state;
  state_e                  state_next;
  logic [`CACHE_IDX_W-1:0] init_idx;
  logic [`CACHE_OFS_W-1:0] beat;
  logic [`CACHE_TAG_W-1:0] req_tag;
  logic [`CACHE_IDX_W-1:0] req_idx;

  assign req_tag = head_i.adr[`CACHE_ADR_W-1 -: `CACHE_TAG_W];
  assign req_idx = head_i.adr[`CACHE_OFS_W +: `CACHE_IDX_W];

  assign init_idx_o  = init_idx;
  assign fill_ofs_o  = beat;
  assign wb_ofs_o    = beat;
  assign ready_en_o  = (state != S_INIT);
  assign ctrl_idle_o = (state == S_IDLE);
  assign done_read_o = !head_i.we;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state    <= S_INIT;
      init_idx <= '0;
      beat     <= '0;
    end
    else
    begin
      state <= state_next;
      if (state == S_INIT)
        init_idx <= init_idx + 1'b1;
      if (mem.cyc && mem.ack)
        beat <= beat + 1'b1;          // Wraps to 0 after the last beat
    end
  end

  // ********************************************************************
  // Next state, line commands and memory bus
  // ********************************************************************
  always_comb
  begin
    state_next  = state;
    cmd_o       = CMD_NONE;
    write_o     = 1'b0;
    pop_o       = 1'b0;
    done_o      = 1'b0;
    ev_access_o = 1'b0;
    ev_fill_o   = 1'b0;
    ev_wb_o     = 1'b0;
    mem.cyc     = 1'b0;
    mem.we      = 1'b0;
    mem.adr     = {req_tag, req_idx, beat};
    mem.wdata   = victim_word_i;
    case (state)
      S_INIT:
      begin
        cmd_o   = CMD_CLEAR_VALID;
        write_o = 1'b1;
        if (init_idx == '1)
          state_next = S_IDLE;
      end
      S_IDLE:
      begin
        if (!empty_i)
          state_next = S_LOOKUP;
      end
      S_LOOKUP:
        state_next = S_COMPARE;       // Way RAM read
      S_COMPARE:
      begin
        cmd_o      = CMD_LOAD;
        state_next = S_HIT;
      end
      S_HIT:
      begin
        if (hit_i)
        begin
          cmd_o       = CMD_APPLY_HIT;
          write_o     = 1'b1;
          pop_o       = 1'b1;
          done_o      = 1'b1;
          ev_access_o = 1'b1;
          state_next  = S_IDLE;
        end
        else if (victim_dirty_i)
          state_next = S_WB;
        else
        begin
          cmd_o      = CMD_SET_TAG;
          state_next = S_FILL;
        end
      end
      S_WB:
      begin
        mem.cyc = 1'b1;
        mem.we  = 1'b1;
        mem.adr = {victim_tag_i, req_idx, beat};
        if (mem.ack && beat == '1)
        begin
          cmd_o      = CMD_SET_TAG;   // Old tag no longer needed
          ev_wb_o    = 1'b1;
          state_next = S_FILL;
        end
      end
      S_FILL:
      begin
        mem.cyc = 1'b1;
        if (mem.ack)
        begin
          cmd_o = CMD_FILL_WORD;
          if (beat == '1)
          begin
            ev_fill_o  = 1'b1;
            state_next = S_REFILL;
          end
        end
      end
      S_REFILL:
      begin
        write_o    = 1'b1;
        state_next = S_LOOKUP;        // Replay as a hit
      end
      default:
        state_next = S_IDLE;
    endcase
  end

endmodule

// ==== source/cache_pkg.sv ====
`include "cache_consts.svh"

package cache_pkg;

  typedef struct packed {
    logic                     we;
    logic [`CACHE_ADR_W-1:0]  adr;
    logic [`CACHE_DATA_W-1:0] wdata;
    logic [3:0]               sel;
  } cache_req_t;

  typedef struct packed {
    logic                           valid;
    logic                           dirty;  // One bit for the whole line
    logic                           lru;    // Set on the way to evict next
    logic [`CACHE_TAG_W-1:0]        tag;
    logic [3:0][`CACHE_DATA_W-1:0]  data;
  } cache_line_t;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_LOAD,
    CMD_APPLY_HIT,
    CMD_SET_TAG,
    CMD_FILL_WORD,
    CMD_CLEAR_VALID
  } ctrl_cmd_e;

  typedef enum logic [1:0] {
    STAT_ACCESS = 2'd0,
    STAT_FILL   = 2'd1,
    STAT_WB     = 2'd2
  } stat_sel_e;

endpackage

// ==== source/cache_top.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module cache_top import cache_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     host_valid_i,
  input  logic                     host_we_i,
  input  logic                     host_stat_i,
  input  logic [`CACHE_ADR_W-1:0]  host_adr_i,
  input  logic [`CACHE_DATA_W-1:0] host_wdata_i,
  input  logic [3:0]               host_sel_i,
  output logic                     host_ready_o,
  output logic                     rsp_valid_o,
  output logic [`CACHE_DATA_W-1:0] rsp_rdata_o,
  output logic                     mem_cyc_o,
  output logic                     mem_we_o,
  output logic [`CACHE_ADR_W-1:0]  mem_adr_o,
  output logic [`CACHE_DATA_W-1:0] mem_wdata_o,
  input  logic [`CACHE_DATA_W-1:0] mem_rdata_i,
  input  logic                     mem_ack_i
);

  cache_req_t               push_data;
  cache_req_t               head;
  logic                     push;
  logic                     full;
  logic                     pop;
  logic                     empty;
  ctrl_cmd_e                cmd;
  logic [`CACHE_IDX_W-1:0]  init_idx;
  logic [`CACHE_OFS_W-1:0]  fill_ofs;
  logic [`CACHE_OFS_W-1:0]  wb_ofs;
  logic                     write;
  logic                     hit;
  logic                     victim_dirty;
  logic [`CACHE_TAG_W-1:0]  victim_tag;
  logic [`CACHE_DATA_W-1:0] victim_word;
  logic [`CACHE_DATA_W-1:0] rd_word;
  logic                     ready_en;
  logic                     ctrl_idle;
  logic                     done;
  logic                     done_read;
  logic                     ev_access;
  logic                     ev_fill;
  logic                     ev_wb;

  way_if     way0_bus ();
  way_if     way1_bus ();
  mem_bus_if mem_bus ();

  assign mem_cyc_o     = mem_bus.cyc;
  assign mem_we_o      = mem_bus.we;
  assign mem_adr_o     = mem_bus.adr;
  assign mem_wdata_o   = mem_bus.wdata;
  assign mem_bus.rdata = mem_rdata_i;
  assign mem_bus.ack   = mem_ack_i;

  req_queue u_queue (
    .clk_i, .rst_i,
    .push_i (push), .push_data_i (push_data), .full_o (full),
    .pop_i (pop), .head_o (head), .empty_o (empty)
  );

  way_ram u_way0 (.clk_i, .port (way0_bus.mem));
  way_ram u_way1 (.clk_i, .port (way1_bus.mem));

  line_path u_line (
    .clk_i, .rst_i,
    .way0 (way0_bus.user), .way1 (way1_bus.user),
    .cmd_i (cmd), .init_idx_i (init_idx),
    .fill_word_i (mem_bus.rdata), .fill_ofs_i (fill_ofs),
    .req_i (head),
    .hit_o (hit), .victim_dirty_o (victim_dirty),
    .victim_tag_o (victim_tag), .victim_word_o (victim_word),
    .wb_ofs_i (wb_ofs), .rd_word_o (rd_word), .write_i (write)
  );

  host_port u_host (
    .clk_i, .rst_i, .ready_en_i (ready_en),
    .host_valid_i, .host_we_i, .host_stat_i, .host_adr_i,
    .host_wdata_i, .host_sel_i, .host_ready_o,
    .rsp_valid_o, .rsp_rdata_o,
    .push_o (push), .push_data_o (push_data), .full_i (full), .empty_i (empty),
    .ctrl_idle_i (ctrl_idle), .done_i (done), .done_read_i (done_read),
    .done_word_i (rd_word),
    .ev_access_i (ev_access), .ev_fill_i (ev_fill), .ev_wb_i (ev_wb)
  );

  cache_ctrl u_ctrl (
    .clk_i, .rst_i,
    .pop_o (pop), .empty_i (empty), .head_i (head),
    .cmd_o (cmd), .init_idx_o (init_idx),
    .fill_ofs_o (fill_ofs), .wb_ofs_o (wb_ofs), .write_o (write),
    .hit_i (hit), .victim_dirty_i (victim_dirty),
    .victim_tag_i (victim_tag), .victim_word_i (victim_word),
    .mem (mem_bus.master),
    .ready_en_o (ready_en), .ctrl_idle_o (ctrl_idle),
    .done_o (done), .done_read_o (done_read),
    .ev_access_o (ev_access), .ev_fill_o (ev_fill), .ev_wb_o (ev_wb)
  );

endmodule

// ==== source/host_port.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module host_port import cache_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     ready_en_i,
  input  logic                     host_valid_i,
  input  logic                     host_we_i,
  input  logic                     host_stat_i,
  input  logic [`CACHE_ADR_W-1:0]  host_adr_i,
  input  logic [`CACHE_DATA_W-1:0] host_wdata_i,
  input  logic [3:0]               host_sel_i,
  output logic                     host_ready_o,
  output logic                     rsp_valid_o,
  output logic [`CACHE_DATA_W-1:0] rsp_rdata_o,
  output logic                     push_o,
  output cache_req_t               push_data_o,
  input  logic                     full_i,
  input  logic                     empty_i,
  input  logic                     ctrl_idle_i,
  input  logic                     done_i,
  input  logic                     done_read_i,
  input  logic [`CACHE_DATA_W-1:0] done_word_i,
  input  logic                     ev_access_i,
  input  logic                     ev_fill_i,
  input  logic                     ev_wb_i
);

  typedef enum logic [1:0] {H_IDLE, H_READ, H_STAT} host_state_e;

  host_state_e              state;
  logic                     accept;
  logic                     read_done;
  logic [`CACHE_DATA_W-1:0] stat_word;
  logic [`CACHE_DATA_W-1:0] cnt_access;
  logic [`CACHE_DATA_W-1:0] cnt_fill;
  logic [`CACHE_DATA_W-1:0] cnt_wb;

  // Stats only once the cache has drained
  always_comb
  begin
    host_ready_o = 1'b0;
    if (ready_en_i && state == H_IDLE)
      host_ready_o = host_stat_i ? (empty_i && ctrl_idle_i) : !full_i;
  end

  assign accept    = host_valid_i && host_ready_o;
  assign read_done = (state == H_READ) && done_i && done_read_i;

  assign push_o            = accept && !host_stat_i;
  assign push_data_o.we    = host_we_i;
  assign push_data_o.adr   = host_adr_i;
  assign push_data_o.wdata = host_wdata_i;
  assign push_data_o.sel   = host_sel_i;

  always_comb
  begin
    case (stat_sel_e'(host_adr_i[1:0]))
      STAT_ACCESS: stat_word = cnt_access;
      STAT_FILL:   stat_word = cnt_fill;
      STAT_WB:     stat_word = cnt_wb;
      default:     stat_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state       <= H_IDLE;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rsp_valid_o <= 1'b0;
      case (state)
        H_IDLE:
        begin
          if (accept && host_stat_i)
          begin
            state       <= H_STAT;
            rsp_valid_o <= 1'b1;
          end
          else if (accept && !host_we_i)
            state <= H_READ;          // Block until the data returns
        end
        H_READ:
        begin
          if (read_done)
          begin
            state       <= H_IDLE;
            rsp_valid_o <= 1'b1;
          end
        end
        default:
          state <= H_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept && host_stat_i)
      rsp_rdata_o <= stat_word;
    else if (read_done)
      rsp_rdata_o <= done_word_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cnt_access <= '0;
      cnt_fill   <= '0;
      cnt_wb     <= '0;
    end
    else
    begin
      cnt_access <= cnt_access + ev_access_i;
      cnt_fill   <= cnt_fill + ev_fill_i;
      cnt_wb     <= cnt_wb + ev_wb_i;
    end
  end

endmodule

// ==== source/line_path.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module line_path import cache_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  way_if.user                      way0,
  way_if.user                      way1,
  input  ctrl_cmd_e                cmd_i,
  input  logic [`CACHE_IDX_W-1:0]  init_idx_i,
  input  logic [`CACHE_DATA_W-1:0] fill_word_i,
  input  logic [`CACHE_OFS_W-1:0]  fill_ofs_i,
  input  cache_req_t               req_i,
  output logic                     hit_o,
  output logic                     victim_dirty_o,
  output logic [`CACHE_TAG_W-1:0]  victim_tag_o,
  output logic [`CACHE_DATA_W-1:0] victim_word_o,
  input  logic [`CACHE_OFS_W-1:0]  wb_ofs_i,
  output logic [`CACHE_DATA_W-1:0] rd_word_o,
  input  logic                     write_i
);

  logic [`CACHE_TAG_W-1:0] req_tag;
  logic [`CACHE_IDX_W-1:0] req_idx;
  logic [`CACHE_OFS_W-1:0] req_ofs;
  logic [`CACHE_IDX_W-1:0] set_adr;
  logic [1:0]              way_hit;
  cache_line_t             lines_q [2];
  cache_line_t             lines_d [2];
  logic                    hit_q;
  logic                    hit_way_q;
  logic                    victim_q;

  assign req_tag = req_i.adr[`CACHE_ADR_W-1 -: `CACHE_TAG_W];
  assign req_idx = req_i.adr[`CACHE_OFS_W +: `CACHE_IDX_W];
  assign req_ofs = req_i.adr[`CACHE_OFS_W-1:0];

  assign way_hit[0] = way0.rline.valid && (way0.rline.tag == req_tag);
  assign way_hit[1] = way1.rline.valid && (way1.rline.tag == req_tag);

  // ********************************************************************
  // Next line contents, written to both ways when write_i is high
  // ********************************************************************
  always_comb
  begin
    lines_d = lines_q;
    case (cmd_i)
      CMD_LOAD:
      begin
        lines_d[0] = way0.rline;
        lines_d[1] = way1.rline;
      end
      CMD_APPLY_HIT:
      begin
        lines_d[hit_way_q].lru  = 1'b0;
        lines_d[~hit_way_q].lru = 1'b1;
        if (req_i.we)
        begin
          for (int b = 0; b < 4; b++)
            if (req_i.sel[b])
              lines_d[hit_way_q].data[req_ofs][8*b +: 8] = req_i.wdata[8*b +: 8];
          lines_d[hit_way_q].dirty = 1'b1;
        end
      end
      CMD_SET_TAG:
      begin
        lines_d[victim_q].tag   = req_tag;
        lines_d[victim_q].valid = 1'b0;
        lines_d[victim_q].dirty = 1'b0;
      end
      CMD_FILL_WORD:
      begin
        lines_d[victim_q].data[fill_ofs_i] = fill_word_i;
        lines_d[victim_q].valid = 1'b1;
        lines_d[victim_q].dirty = 1'b0;
      end
      CMD_CLEAR_VALID:
      begin
        lines_d[0] = '0;
        lines_d[1] = '0;
      end
      default:
      begin
        lines_d = lines_q;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    lines_q <= lines_d;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      hit_q     <= 1'b0;
      hit_way_q <= 1'b0;
      victim_q  <= 1'b0;
    end
    else if (cmd_i == CMD_LOAD)
    begin
      hit_q     <= |way_hit;
      hit_way_q <= way_hit[1];
      victim_q  <= way1.rline.lru;    // Way 0 unless way 1 is older
    end
  end

  assign hit_o          = hit_q;
  assign victim_dirty_o = lines_q[victim_q].valid && lines_q[victim_q].dirty;
  assign victim_tag_o   = lines_q[victim_q].tag;
  assign victim_word_o  = lines_q[victim_q].data[wb_ofs_i];
  assign rd_word_o      = lines_q[hit_way_q].data[req_ofs];

  assign set_adr     = (cmd_i == CMD_CLEAR_VALID) ? init_idx_i : req_idx;
  assign way0.adr    = set_adr;
  assign way1.adr    = set_adr;
  assign way0.we     = write_i;
  assign way1.we     = write_i;
  assign way0.wline  = lines_d[0];
  assign way1.wline  = lines_d[1];

endmodule

// ==== source/mem_bus_if.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

interface mem_bus_if ();

  logic                     cyc;
  logic                     we;
  logic [`CACHE_ADR_W-1:0]  adr;
  logic [`CACHE_DATA_W-1:0] wdata;
  logic [`CACHE_DATA_W-1:0] rdata;
  logic                     ack;    // Beat done when cyc and ack

  modport master (
    output cyc, we, adr, wdata,
    input  rdata, ack
  );

  modport slave (
    input  cyc, we, adr, wdata,
    output rdata, ack
  );

endinterface

// ==== source/req_queue.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module req_queue import cache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       push_i,
  input  cache_req_t push_data_i,
  output logic       full_o,
  input  logic       pop_i,
  output cache_req_t head_o,
  output logic       empty_o
);

  localparam int LOG = `CACHE_QDEPTH_LOG;

  cache_req_t   entries [1 << LOG];
  logic [LOG:0] wr_ptr;               // Top bit is the wrap flag
  logic [LOG:0] rd_ptr;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[LOG] != rd_ptr[LOG]) &&
                   (wr_ptr[LOG-1:0] == rd_ptr[LOG-1:0]);
  assign head_o  = entries[rd_ptr[LOG-1:0]];

  always_ff @(posedge clk_i)
  begin
    if (push_i && !full_o)
      entries[wr_ptr[LOG-1:0]] <= push_data_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push_i && !full_o)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i && !empty_o)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// ==== source/way_if.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

interface way_if import cache_pkg::*; ();

  logic [`CACHE_IDX_W-1:0] adr;
  logic                    we;
  cache_line_t             wline;
  cache_line_t             rline;   // Registered, one cycle after adr

  modport mem (
    input  adr, we, wline,
    output rline
  );

  modport user (
    output adr, we, wline,
    input  rline
  );

endinterface

// ==== source/way_ram.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module way_ram import cache_pkg::*; (
  input logic clk_i,
  way_if.mem  port
);

  cache_line_t lines [1 << `CACHE_IDX_W];

  always_ff @(posedge clk_i)
  begin
    if (port.we)
      lines[port.adr] <= port.wline;
    port.rline <= lines[port.adr];     // Old line on same-cycle write
  end

endmodule

// ==== tb/cache_tb.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module cache_tb;

  localparam int TIMEOUT = 2000;
  localparam int SETS    = 1 << `CACHE_IDX_W;

  logic                     clk_i;
  logic                     rst_i;
  logic                     host_valid_i;
  logic                     host_we_i;
  logic                     host_stat_i;
  logic [`CACHE_ADR_W-1:0]  host_adr_i;
  logic [`CACHE_DATA_W-1:0] host_wdata_i;
  logic [3:0]               host_sel_i;
  logic                     host_ready_o;
  logic                     rsp_valid_o;
  logic [`CACHE_DATA_W-1:0] rsp_rdata_o;
  logic                     mem_cyc_o;
  logic                     mem_we_o;
  logic [`CACHE_ADR_W-1:0]  mem_adr_o;
  logic [`CACHE_DATA_W-1:0] mem_wdata_o;
  logic [`CACHE_DATA_W-1:0] mem_rdata_i;
  logic                     mem_ack_i;
  logic                     slow;
  logic                     log_valid;
  logic                     log_we;
  logic [`CACHE_ADR_W-1:0]  log_adr;
  logic [`CACHE_DATA_W-1:0] log_data;

  // Golden memory and per-set cache model
  logic [`CACHE_DATA_W-1:0] golden [logic [`CACHE_ADR_W-1:0]];
  logic [`CACHE_TAG_W-1:0]  set_tag [SETS][2];
  logic [1:0]               set_valid [SETS];
  logic [1:0]               set_dirty [SETS];
  logic                     set_victim [SETS];   // Way to evict next
  logic [`CACHE_ADR_W-1:0]  exp_wr [$];
  logic [`CACHE_ADR_W-1:0]  wr_log [$];
  logic [`CACHE_DATA_W-1:0] exp_rsp;
  logic [`CACHE_DATA_W-1:0] wb_exp;
  int                       exp_access = 0;
  int                       exp_fill = 0;
  int                       exp_wb = 0;
  int                       beats = 0;
  int                       rd_beats = 0;
  int                       stalls = 0;
  int                       err_cnt = 0;
  int                       err_mark = 0;
  int                       pass_cnt = 0;
  int                       fail_cnt = 0;
  int                       mark;
  int                       cnt;

  cache_top UUT (.*);

  mem_model u_mem (
    .clk_i, .rst_i, .slow_i (slow),
    .cyc_i (mem_cyc_o), .we_i (mem_we_o), .adr_i (mem_adr_o), .wdata_i (mem_wdata_o),
    .rdata_o (mem_rdata_i), .ack_o (mem_ack_i),
    .log_valid_o (log_valid), .log_we_o (log_we), .log_adr_o (log_adr), .log_data_o (log_data)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [`CACHE_DATA_W-1:0] golden_word(input logic [`CACHE_ADR_W-1:0] adr);
    if (golden.exists(adr))
      return golden[adr];
    return {adr[7:0], adr} ^ 32'h5ac3_0f96;   // Initial memory pattern
  endfunction

  // ********************************************************************
  // Checks
  // ********************************************************************
  rsp_check: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o |-> rsp_rdata_o == exp_rsp)
  else
  begin
    $display("MISMATCH rsp_rdata_o: got %h, expected %h",
             $sampled(rsp_rdata_o), $sampled(exp_rsp));
    err_cnt++;
  end

  // Written-back words must match the golden line
  always @(negedge clk_i)
  begin
    if (log_valid)
      wb_exp = golden_word(log_adr);
  end

  wb_check: assert property (@(posedge clk_i) disable iff (rst_i)
    (log_valid && log_we) |-> log_data == wb_exp)
  else
  begin
    $display("MISMATCH mem_wdata_o: got %h, expected %h", $sampled(log_data), $sampled(wb_exp));
    err_cnt++;
  end

  always @(posedge clk_i)
  begin
    if (!rst_i && log_valid)
    begin
      beats++;
      if (log_we)
        wr_log.push_back(log_adr);
      else
        rd_beats++;
    end
  end

  // ********************************************************************
  // Reference model updated in acceptance order
  // ********************************************************************
  task automatic model_access(input logic [`CACHE_ADR_W-1:0] adr, input logic we,
                              input logic [`CACHE_DATA_W-1:0] wdata, input logic [3:0] sel);
    logic [`CACHE_TAG_W-1:0]  tag;
    logic [`CACHE_IDX_W-1:0]  idx;
    logic [`CACHE_DATA_W-1:0] word;
    int                       w;
    tag = adr[`CACHE_ADR_W-1 -: `CACHE_TAG_W];
    idx = adr[`CACHE_OFS_W +: `CACHE_IDX_W];
    w   = -1;
    for (int i = 0; i < 2; i++)
      if (set_valid[idx][i] && set_tag[idx][i] == tag)
        w = i;
    if (w < 0)
    begin
      w = set_victim[idx];
      if (set_valid[idx][w] && set_dirty[idx][w])
      begin
        exp_wb++;
        for (int k = 0; k < 4; k++)
          exp_wr.push_back({set_tag[idx][w], idx, 2'(k)});
      end
      set_tag[idx][w]   = tag;
      set_valid[idx][w] = 1'b1;
      set_dirty[idx][w] = 1'b0;
      exp_fill++;
    end
    set_victim[idx] = (w == 0);
    if (we)
    begin
      set_dirty[idx][w] = 1'b1;
      word = golden_word(adr);
      for (int b = 0; b < 4; b++)
        if (sel[b])
          word[8*b +: 8] = wdata[8*b +: 8];
      golden[adr] = word;
    end
    exp_access++;
  endtask

  task automatic abort_run(input string what);
    $display("Timeout waiting for %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic issue(input logic we, input logic stat, input logic [`CACHE_ADR_W-1:0] adr,
                       input logic [`CACHE_DATA_W-1:0] wdata, input logic [3:0] sel);
    int n;
    host_valid_i = 1'b1;
    host_we_i    = we;
    host_stat_i  = stat;
    host_adr_i   = adr;
    host_wdata_i = wdata;
    host_sel_i   = sel;
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
      if (!host_ready_o)
        stalls++;
      if (n > TIMEOUT)
        abort_run("request handshake");
    end while (!host_ready_o);
    #1;
    host_valid_i = 1'b0;
    host_stat_i  = 1'b0;
  endtask

  task automatic write_word(input logic [`CACHE_ADR_W-1:0] adr,
                            input logic [`CACHE_DATA_W-1:0] wdata, input logic [3:0] sel);
    model_access(adr, 1'b1, wdata, sel);
    issue(1'b1, 1'b0, adr, wdata, sel);
  endtask

  task automatic read_word(input logic [`CACHE_ADR_W-1:0] adr);
    int n;
    exp_rsp = golden_word(adr);
    model_access(adr, 1'b0, '0, '0);
    issue(1'b0, 1'b0, adr, '0, '0);
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        abort_run("read response");
    end while (!rsp_valid_o);
    #1;
  endtask

  task automatic read_stat(input logic [1:0] sel, input int expected);
    exp_rsp = expected;
    issue(1'b0, 1'b1, {22'd0, sel}, '0, '0);
    @(posedge clk_i);
    assert (rsp_valid_o)
    else
    begin
      $display("Statistics response missing one cycle after acceptance");
      err_cnt++;
    end
    #1;
  endtask

  task automatic finish_test(input string name);
    int errs;
    assert (wr_log.size() == exp_wr.size())
    else
    begin
      $display("MISMATCH write-back beats: got %h, expected %h", wr_log.size(), exp_wr.size());
      err_cnt++;
    end
    for (int i = 0; i < wr_log.size() && i < exp_wr.size(); i++)
      assert (wr_log[i] == exp_wr[i])
      else
      begin
        $display("MISMATCH mem_adr_o: got %h, expected %h", wr_log[i], exp_wr[i]);
        err_cnt++;
      end
    wr_log.delete();
    exp_wr.delete();
    errs     = err_cnt - err_mark;
    err_mark = err_cnt;
    if (errs == 0)
      pass_cnt++;
    else
      fail_cnt++;
    $display("Test %s: %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  // ********************************************************************
  // Stimulus
  // ********************************************************************
  initial
  begin
    void'($urandom(2832));
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    host_valid_i = 1'b0;
    host_we_i    = 1'b0;
    host_stat_i  = 1'b0;
    host_adr_i   = '0;
    host_wdata_i = '0;
    host_sel_i   = '0;
    slow         = 1'b0;
    for (int s = 0; s < SETS; s++)
    begin
      set_valid[s]  = '0;
      set_dirty[s]  = '0;
      set_victim[s] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    assert (!host_ready_o && !rsp_valid_o && !mem_cyc_o)
    else
    begin
      $display("host_ready_o, rsp_valid_o or mem_cyc_o high during reset");
      err_cnt++;
    end
    #1;
    rst_i = 1'b0;

    cnt = 0;
    do
    begin
      @(posedge clk_i);
      cnt++;
      if (cnt > TIMEOUT)
        abort_run("host_ready_o after reset");
    end while (!host_ready_o);
    #1;
    assert (cnt > SETS)
    else
    begin
      $display("host_ready_o rose before the init walk over all sets ended");
      err_cnt++;
    end
    mark = rd_beats;
    read_word(24'h12_3456);                  // Cold miss
    assert (rd_beats - mark == 4)
    else
    begin
      $display("MISMATCH mem read beats: got %h, expected %h", rd_beats - mark, 4);
      err_cnt++;
    end
    finish_test("1 read miss fill");

    mark = beats;
    write_word(24'h12_3456, $urandom, 4'b0101);
    read_word(24'h12_3456);
    assert (beats == mark)
    else
    begin
      $display("Memory traffic seen on a cache hit");
      err_cnt++;
    end
    finish_test("2 byte write hit");

    // Three tags in set 5 so the last two misses evict dirty lines
    write_word({16'h0100, 6'd5, 2'd1}, $urandom, 4'hf);
    write_word({16'h0200, 6'd5, 2'd2}, $urandom, 4'b1100);
    write_word({16'h0300, 6'd5, 2'd3}, $urandom, 4'hf);
    read_word({16'h0100, 6'd5, 2'd1});
    finish_test("3 dirty eviction");

    read_stat(2'd0, exp_access);
    read_stat(2'd1, exp_fill);
    read_stat(2'd2, exp_wb);
    read_stat(2'd3, 0);
    finish_test("4 statistics");

    slow   = 1'b1;
    stalls = 0;
    for (int i = 0; i < 10; i++)
      write_word({16'h0777, 6'(40 + i % 2), 2'(i % 3)}, $urandom, 4'hf);
    assert (stalls > 0)
    else
    begin
      $display("host_ready_o never dropped during the write burst");
      err_cnt++;
    end
    for (int i = 0; i < 6; i++)
      read_word({16'h0777, 6'(40 + i % 2), 2'(i % 3)});
    slow = 1'b0;
    read_stat(2'd0, exp_access);
    finish_test("5 queue back-pressure");

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module mem_model (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     slow_i,
  input  logic                     cyc_i,
  input  logic                     we_i,
  input  logic [`CACHE_ADR_W-1:0]  adr_i,
  input  logic [`CACHE_DATA_W-1:0] wdata_i,
  output logic [`CACHE_DATA_W-1:0] rdata_o,
  output logic                     ack_o,
  output logic                     log_valid_o,
  output logic                     log_we_o,
  output logic [`CACHE_ADR_W-1:0]  log_adr_o,
  output logic [`CACHE_DATA_W-1:0] log_data_o
);

  logic [`CACHE_DATA_W-1:0] words [logic [`CACHE_ADR_W-1:0]];
  int unsigned              wait_cnt;

  // Untouched words follow a pattern over the whole address
  function automatic logic [`CACHE_DATA_W-1:0] stored_word(
    input logic [`CACHE_ADR_W-1:0] adr
  );
    if (words.exists(adr))
      return words[adr];
    return {adr[7:0], adr} ^ 32'h5ac3_0f96;
  endfunction

  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ack_o       <= 1'b0;
      rdata_o     <= '0;
      log_valid_o <= 1'b0;
      wait_cnt    <= 0;
    end
    else
    begin
      log_valid_o <= 1'b0;
      if (ack_o)
      begin
        ack_o       <= 1'b0;                 // Beat completes at this edge
        log_valid_o <= 1'b1;
        log_we_o    <= we_i;
        log_adr_o   <= adr_i;
        log_data_o  <= we_i ? wdata_i : rdata_o;
        if (we_i)
          words[adr_i] = wdata_i;
        wait_cnt <= $urandom % 4 + (slow_i ? 10 : 0);
      end
      else if (cyc_i)
      begin
        if (wait_cnt == 0)
        begin
          ack_o   <= 1'b1;
          rdata_o <= stored_word(adr_i);
        end
        else
          wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule
